// File: uncore_top.f
hdl/apb_pkg.sv
hdl/uncore_pkg.sv
hdl/uncore_decoder.sv
hdl/uncore_bootrom.sv
hdl/uncore_clint.sv
hdl/uncore_dram_bridge.sv
hdl/uncore_top.sv
dv/uncore_tb.sv

// File: dv/uncore_tb.sv
// Uncore testbench, APB master on the core port plus a DRAM model on the external memory port
`timescale 1ns/1ps

module uncore_tb
    import apb_pkg::*;
    import uncore_pkg::*;
();

    // Same values as the DUT defaults
    localparam int unsigned CLK_PERIOD   = 20;
    localparam int unsigned DRAM_TIMEOUT = 64;
    // Upper bound on transfers issued by all tests
    localparam int unsigned NUM_XFERS    = 60;
    localparam int unsigned WDOG_CYCLES  = NUM_XFERS * (DRAM_TIMEOUT + 8) + 200;
    localparam int unsigned DRAM_WORDS   = 8;

    logic      clk;
    logic      uncore_areset_n;
    apb_req_t  up_req;
    apb_resp_t up_resp;
    apb_req_t  mem_req;
    apb_resp_t mem_resp;
    logic      ipi;
    logic      timer_irq;

    logic [31:0] lfsr_q = 32'h35ef_cdb4;
    int unsigned err_cnt;
    int unsigned xfer_cnt;
    int unsigned test_cnt;
    int unsigned test_fail_cnt;

    // Expected response of the transfer in flight
    logic [31:0] exp_data;
    logic        exp_err;
    logic        chk_data;

    // Reference state built from the writes
    logic [31:0] ref_mem [logic [31:0]];
    logic        ref_msip;

    // Memory model state
    logic [31:0] mem [logic [31:0]];
    logic        mem_stall;
    logic [31:0] mem_last_ofs;
    int unsigned mem_wait;

    uncore_top i_dut (
        .clk             (clk),
        .uncore_areset_n (uncore_areset_n),
        .up_req_i        (up_req),
        .up_resp_o       (up_resp),
        .mem_req_o       (mem_req),
        .mem_resp_i      (mem_resp),
        .ipi_o           (ipi),
        .timer_irq_o     (timer_irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] val;
        val = '0;
        for (int unsigned i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    function automatic logic is_rom(input logic [31:0] addr);
        return addr >= ROM_BASE && addr < ROM_END;
    endfunction

    function automatic logic is_clint(input logic [31:0] addr);
        return addr >= CLINT_BASE && addr < CLINT_END;
    endfunction

    function automatic logic is_dram(input logic [31:0] addr);
        return addr >= DRAM_BASE && addr - DRAM_BASE < DRAM_SIZE;
    endfunction

    // Reference read data from the address map rules
    function automatic logic [31:0] expected_rdata(input logic [31:0] addr);
        if (is_rom(addr)) begin
            return BOOT_IMAGE[((addr - ROM_BASE) >> 2) % BOOT_WORDS];
        end else if (is_clint(addr)) begin
            return (addr == CLINT_BASE + MSIP_OFS) ? {31'd0, ref_msip} : 32'd0;
        end else if (is_dram(addr)) begin
            return ref_mem.exists(addr) ? ref_mem[addr] : 32'd0;
        end
        return 32'd0;
    endfunction

    // ROM writes, holes in the map and a dead memory port all answer with an error
    function automatic logic expected_err(input logic [31:0] addr, input logic wr);
        if (is_rom(addr)) begin
            return wr;
        end else if (is_clint(addr)) begin
            return 1'b0;
        end else if (is_dram(addr)) begin
            return mem_stall;
        end
        return 1'b1;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_cnt++;
        $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    endtask

    task automatic finish_test(input string name, input int unsigned errs_before);
        test_cnt++;
        if (err_cnt != errs_before) begin
            test_fail_cnt++;
        end
        $display("test %-10s %s", name, (err_cnt == errs_before) ? "ok" : "failed");
    endtask

    // --------------------
    // APB master
    // --------------------
    task automatic run_transfer(input logic [31:0] addr, input logic wr,
                                input logic [31:0] wdata, input logic chk,
                                output logic [31:0] rdata);
        int unsigned cycles;
        logic        ready;
        exp_data = expected_rdata(addr);
        exp_err  = expected_err(addr, wr);
        chk_data = chk;
        @(negedge clk);
        up_req = '{paddr: addr, pwrite: wr, pwdata: wdata, psel: 1'b1, penable: 1'b0};
        @(negedge clk);
        up_req.penable = 1'b1;
        cycles = 0;
        ready  = 1'b0;
        while (!ready && cycles < DRAM_TIMEOUT + 8) begin
            @(posedge clk);
            ready = up_resp.pready;
            rdata = up_resp.prdata;
            cycles++;
        end
        if (!ready) begin
            err_cnt++;
            $display("Error at %0t ns: transfer to %h never got pready", $time, addr);
        end
        @(negedge clk);
        up_req.psel    = 1'b0;
        up_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        run_transfer(addr, 1'b1, data, 1'b0, unused);
        // Track what the slaves should now hold
        if (is_dram(addr) && !mem_stall) begin
            ref_mem[addr] = data;
        end
        if (addr == CLINT_BASE + MSIP_OFS) begin
            ref_msip = data[0];
        end
    endtask

    task automatic apb_read(input logic [31:0] addr, input logic chk,
                            output logic [31:0] data);
        run_transfer(addr, 1'b0, 32'd0, chk, data);
    endtask

    // Compare every completed upstream transfer
    always @(posedge clk) begin
        if (uncore_areset_n && up_req.psel && up_req.penable && up_resp.pready) begin
            xfer_cnt++;
            if (up_resp.pslverr !== exp_err) begin
                report_mismatch("pslverr", up_resp.pslverr, exp_err);
            end
            if (!up_req.pwrite && chk_data && up_resp.prdata !== exp_data) begin
                report_mismatch("prdata", up_resp.prdata, exp_data);
            end
            // Aborted transfer releases the external port as it ends
            if (mem_stall && mem_req.psel !== 1'b0) begin
                report_mismatch("mem_req_o.psel", mem_req.psel, 0);
            end
        end
    end

    // --------------------
    // External memory model
    // --------------------
    // Samples on the rising edge, answers on the falling edge
    always begin : mem_model
        apb_req_t snap;
        logic     was_ready;
        @(posedge clk);
        snap      = mem_req;
        was_ready = mem_resp.pready;
        // Offset of a transfer closing on this edge
        if (snap.psel && snap.penable && was_ready) begin
            mem_last_ofs = snap.paddr;
        end
        @(negedge clk);
        if (snap.psel && snap.penable && was_ready) begin
            // Transfer closed on the rising edge
            if (snap.pwrite) begin
                mem[snap.paddr] = snap.pwdata;
            end
            mem_resp = '0;
        end else if (snap.psel && !snap.penable) begin
            mem_wait        = rand_bits(2);
            mem_resp.pready = !mem_stall && (mem_wait == 0);
        end else if (snap.psel && snap.penable) begin
            if (mem_wait != 0) begin
                mem_wait--;
            end
            mem_resp.pready = !mem_stall && (mem_wait == 0);
        end else begin
            mem_resp = '0;
        end
        mem_resp.prdata = (mem_resp.pready && !snap.pwrite && mem.exists(snap.paddr)) ?
                          mem[snap.paddr] : 32'd0;
    end

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run is stuck", WDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    // --------------------
    // Tests
    // --------------------
    initial begin
        logic [31:0] data;
        logic [31:0] t0;
        logic [31:0] t1;
        logic [31:0] dram_addr [DRAM_WORDS];
        int unsigned errs;
        int unsigned i;

        clk             = 1'b0;
        uncore_areset_n = 1'b0;
        up_req          = '0;
        mem_resp        = '0;
        mem_stall       = 1'b0;
        mem_last_ofs    = '1;
        ref_msip        = 1'b0;
        err_cnt         = 0;
        xfer_cnt        = 0;
        test_cnt        = 0;
        test_fail_cnt   = 0;
        chk_data        = 1'b0;
        exp_err         = 1'b0;
        exp_data        = '0;
        repeat (2) @(negedge clk);
        uncore_areset_n = 1'b1;

        // Quiet outputs out of reset
        errs = err_cnt;
        @(negedge clk);
        if (ipi !== 1'b0) report_mismatch("ipi_o", ipi, 0);
        if (timer_irq !== 1'b0) report_mismatch("timer_irq_o", timer_irq, 0);
        if (mem_req.psel !== 1'b0) report_mismatch("mem_req_o.psel", mem_req.psel, 0);
        if (up_resp.pready !== 1'b0) report_mismatch("up_resp_o.pready", up_resp.pready, 0);
        finish_test("reset", errs);

        // Random word addresses, image aliases every 16 words
        errs = err_cnt;
        for (i = 0; i < 20; i++) begin
            apb_read(ROM_BASE + (rand_bits(14) << 2), 1'b1, data);
        end
        apb_write(ROM_BASE + 32'h10, 32'hdead_beef);
        finish_test("bootrom", errs);

        errs = err_cnt;
        apb_read(32'h1000_0000, 1'b1, data);
        apb_read(32'h0300_0000, 1'b1, data);
        finish_test("unmapped", errs);

        // Writes then reads, each checked for the rebased address
        errs = err_cnt;
        for (i = 0; i < DRAM_WORDS; i++) begin
            dram_addr[i] = DRAM_BASE + (rand_bits(12) << 2);
            mem_last_ofs = '1;
            apb_write(dram_addr[i], rand_bits(32));
            if (mem_last_ofs !== dram_addr[i] - DRAM_BASE) begin
                report_mismatch("mem_req_o.paddr", mem_last_ofs, dram_addr[i] - DRAM_BASE);
            end
        end
        for (i = 0; i < DRAM_WORDS; i++) begin
            mem_last_ofs = '1;
            apb_read(dram_addr[i], 1'b1, data);
            if (mem_last_ofs !== dram_addr[i] - DRAM_BASE) begin
                report_mismatch("mem_req_o.paddr", mem_last_ofs, dram_addr[i] - DRAM_BASE);
            end
        end
        finish_test("dram", errs);

        // Dead memory port
        errs = err_cnt;
        mem_stall = 1'b1;
        apb_read(DRAM_BASE + 32'h100, 1'b0, data);
        mem_stall = 1'b0;
        finish_test("timeout", errs);

        errs = err_cnt;
        apb_write(CLINT_BASE + MSIP_OFS, 32'd1);
        if (ipi !== 1'b1) report_mismatch("ipi_o", ipi, 1);
        apb_read(CLINT_BASE + MSIP_OFS, 1'b1, data);
        apb_write(CLINT_BASE + MSIP_OFS, 32'd0);
        if (ipi !== 1'b0) report_mismatch("ipi_o", ipi, 0);
        apb_read(CLINT_BASE + MTIME_LO_OFS, 1'b0, t0);
        apb_read(CLINT_BASE + MTIME_LO_OFS, 1'b0, t1);
        if (t1 < t0) begin
            err_cnt++;
            $display("Error at %0t ns: mtime went backwards from %0d to %0d", $time, t0, t1);
        end
        // Clear mtime first, compare high half last so it never passes early
        apb_write(CLINT_BASE + MTIME_HI_OFS, 32'd0);
        apb_write(CLINT_BASE + MTIME_LO_OFS, 32'd0);
        apb_write(CLINT_BASE + MTIMECMP_LO_OFS, 32'd40);
        apb_write(CLINT_BASE + MTIMECMP_HI_OFS, 32'd0);
        // Registered compare sees the new mtimecmp one cycle later
        @(negedge clk);
        if (timer_irq !== 1'b0) report_mismatch("timer_irq_o", timer_irq, 0);
        for (i = 0; i < 200 && !timer_irq; i++) begin
            @(negedge clk);
        end
        if (!timer_irq) begin
            err_cnt++;
            $display("Error at %0t ns: timer_irq_o did not rise within 200 cycles", $time);
        end
        apb_write(CLINT_BASE + MTIMECMP_LO_OFS, 32'hffff_ffff);
        apb_write(CLINT_BASE + MTIMECMP_HI_OFS, 32'hffff_ffff);
        @(negedge clk);
        if (timer_irq !== 1'b0) report_mismatch("timer_irq_o", timer_irq, 0);
        finish_test("clint", errs);

        $display("%0d tests, %0d failed, %0d transfers, %0d errors",
                 test_cnt, test_fail_cnt, xfer_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/uncore_top.sv
// Uncore top level seen from the core's APB port, wires decoder and the three targets
`timescale 1ns/1ps

module uncore_top
    import apb_pkg::*;
#(
    // Clock cycles per mtime increment
    parameter int unsigned RTC_DIV      = 2,
    // Access cycles before a stalled DRAM transfer is aborted
    parameter int unsigned DRAM_TIMEOUT = 64
) (
    input  logic      clk,
    input  logic      uncore_areset_n,
    // Core memory port
    input  apb_req_t  up_req_i,
    output apb_resp_t up_resp_o,
    // External memory port, offset addressing
    output apb_req_t  mem_req_o,
    input  apb_resp_t mem_resp_i,
    // Hart interrupts
    output logic      ipi_o,
    output logic      timer_irq_o
);

    // Decoder to target links
    apb_req_t  rom_req;
    apb_resp_t rom_resp;
    apb_req_t  clint_req;
    apb_resp_t clint_resp;
    apb_req_t  dram_req;
    apb_resp_t dram_resp;

    // --------------------
    // Address decoder
    // --------------------
    uncore_decoder i_decoder (
        .clk             (clk),
        .uncore_areset_n (uncore_areset_n),
        .up_req_i        (up_req_i),
        .up_resp_o       (up_resp_o),
        .rom_req_o       (rom_req),
        .rom_resp_i      (rom_resp),
        .clint_req_o     (clint_req),
        .clint_resp_i    (clint_resp),
        .dram_req_o      (dram_req),
        .dram_resp_i     (dram_resp)
    );

    // --------------------
    // Targets
    // --------------------
    uncore_bootrom i_bootrom (
        .req_i  (rom_req),
        .resp_o (rom_resp)
    );

    uncore_clint #(
        .RTC_DIV (RTC_DIV)
    ) i_clint (
        .clk             (clk),
        .uncore_areset_n (uncore_areset_n),
        .req_i           (clint_req),
        .resp_o          (clint_resp),
        .ipi_o           (ipi_o),
        .timer_irq_o     (timer_irq_o)
    );

    uncore_dram_bridge #(
        .DRAM_TIMEOUT (DRAM_TIMEOUT)
    ) i_dram_bridge (
        .clk             (clk),
        .uncore_areset_n (uncore_areset_n),
        .req_i           (dram_req),
        .resp_o          (dram_resp),
        .mem_req_o       (mem_req_o),
        .mem_resp_i      (mem_resp_i)
    );

endmodule

// File: hdl/uncore_dram_bridge.sv
// DRAM window bridge, rebases addresses onto the external memory port and aborts stalled transfers
`timescale 1ns/1ps

module uncore_dram_bridge
    import apb_pkg::*;
    import uncore_pkg::*;
#(
    // Access cycles allowed without pready
    parameter int unsigned DRAM_TIMEOUT = 64
) (
    input  logic      clk,
    input  logic      uncore_areset_n,
    input  apb_req_t  req_i,
    output apb_resp_t resp_o,
    output apb_req_t  mem_req_o,
    input  apb_resp_t mem_resp_i
);

    localparam int unsigned CNT_W = $clog2(DRAM_TIMEOUT + 1);

    logic             access;
    logic             stall;
    logic             timeout;
    logic [CNT_W-1:0] wait_cnt_q;

    assign access = req_i.psel && req_i.penable;
    assign stall  = access && !mem_resp_i.pready;
    // Fires on the last allowed stalled cycle
    assign timeout = stall && (wait_cnt_q == CNT_W'(DRAM_TIMEOUT - 1));

    // --------------------
    // Wait counter
    // --------------------
    always_ff @(posedge clk or negedge uncore_areset_n) begin
        if (!uncore_areset_n) begin
            wait_cnt_q <= '0;
        end else if (stall && !timeout) begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
        end else begin
            // Done, aborted or idle
            wait_cnt_q <= '0;
        end
    end

    // --------------------
    // External request
    // --------------------
    // Held as is while the memory stalls
    always_comb begin
        mem_req_o         = req_i;
        mem_req_o.paddr   = req_i.paddr - DRAM_BASE;
        mem_req_o.psel    = req_i.psel && !timeout;
        mem_req_o.penable = req_i.penable && !timeout;
    end

    // --------------------
    // Upstream response
    // --------------------
    assign resp_o.prdata  = access ? mem_resp_i.prdata : '0;
    assign resp_o.pready  = access && (mem_resp_i.pready || timeout);
    assign resp_o.pslverr = access && (mem_resp_i.pslverr || timeout);

endmodule

// File: hdl/uncore_clint.sv
// Core-local interruptor for one hart, msip, mtimecmp and a divided-tick mtime over APB
`timescale 1ns/1ps

module uncore_clint
    import apb_pkg::*;
    import uncore_pkg::*;
#(
    // Clock cycles per mtime increment
    parameter int unsigned RTC_DIV = 2
) (
    input  logic      clk,
    input  logic      uncore_areset_n,
    input  apb_req_t  req_i,
    output apb_resp_t resp_o,
    output logic      ipi_o,
    output logic      timer_irq_o
);

    localparam int unsigned DIV_W = (RTC_DIV > 1) ? $clog2(RTC_DIV) : 1;

    logic [DIV_W-1:0]  div_cnt_q;
    logic              tick;
    logic              msip_q;
    logic [63:0]       mtimecmp_q;
    logic [63:0]       mtime_q;
    logic              timer_irq_q;
    logic [ADDR_W-1:0] ofs;
    logic              access;
    logic              wr_en;
    logic [DATA_W-1:0] rdata;

    assign ofs    = req_i.paddr - CLINT_BASE;
    assign access = req_i.psel && req_i.penable;
    // Lands on the edge that closes access
    assign wr_en  = access && req_i.pwrite;

    // --------------------
    // Tick divider
    // --------------------
    assign tick = (div_cnt_q == DIV_W'(RTC_DIV - 1));

    always_ff @(posedge clk or negedge uncore_areset_n) begin
        if (!uncore_areset_n) begin
            div_cnt_q <= '0;
        end else if (tick) begin
            div_cnt_q <= '0;
        end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
        end
    end

    // --------------------
    // Registers
    // --------------------
    always_ff @(posedge clk or negedge uncore_areset_n) begin
        if (!uncore_areset_n) begin
            msip_q     <= 1'b0;
            // All ones keeps the timer interrupt quiet out of reset
            mtimecmp_q <= '1;
            mtime_q    <= '0;
        end else begin
            if (wr_en && ofs == MSIP_OFS) begin
                msip_q <= req_i.pwdata[0];
            end
            if (wr_en && ofs == MTIMECMP_LO_OFS) begin
                mtimecmp_q[31:0] <= req_i.pwdata;
            end
            if (wr_en && ofs == MTIMECMP_HI_OFS) begin
                mtimecmp_q[63:32] <= req_i.pwdata;
            end
            // Software write beats the tick
            if (wr_en && ofs == MTIME_LO_OFS) begin
                mtime_q[31:0] <= req_i.pwdata;
            end else if (wr_en && ofs == MTIME_HI_OFS) begin
                mtime_q[63:32] <= req_i.pwdata;
            end else if (tick) begin
                mtime_q <= mtime_q + 64'd1;
            end
        end
    end

    // Compare registered, one cycle behind the counters
    always_ff @(posedge clk or negedge uncore_areset_n) begin
        if (!uncore_areset_n) begin
            timer_irq_q <= 1'b0;
        end else begin
            timer_irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        case (ofs)
            MSIP_OFS:        rdata = {{(DATA_W-1){1'b0}}, msip_q};
            MTIMECMP_LO_OFS: rdata = mtimecmp_q[31:0];
            MTIMECMP_HI_OFS: rdata = mtimecmp_q[63:32];
            MTIME_LO_OFS:    rdata = mtime_q[31:0];
            MTIME_HI_OFS:    rdata = mtime_q[63:32];
            // Holes read as zero, never an error
            default:         rdata = '0;
        endcase
    end

    assign resp_o.prdata  = (access && !req_i.pwrite) ? rdata : '0;
    assign resp_o.pready  = access;
    assign resp_o.pslverr = 1'b0;

    assign ipi_o       = msip_q;
    assign timer_irq_o = timer_irq_q;

endmodule

// File: hdl/uncore_bootrom.sv
// Read-only boot image target, answers in the first access cycle
`timescale 1ns/1ps

module uncore_bootrom
    import apb_pkg::*;
    import uncore_pkg::*;
(
    input  apb_req_t  req_i,
    output apb_resp_t resp_o
);

    localparam int unsigned IDX_W = $clog2(BOOT_WORDS);

    logic              access;
    logic [ADDR_W-1:0] ofs;
    logic [IDX_W-1:0]  word_idx;

    // --------------------
    // Address to word index
    // --------------------
    assign access = req_i.psel && req_i.penable;
    assign ofs    = req_i.paddr - ROM_BASE;

    // Upper bits dropped, image repeats over the region
    assign word_idx = ofs[2 +: IDX_W];

    // --------------------
    // Response
    // --------------------
    // No wait states
    assign resp_o.pready = access;

    // Writes are refused
    assign resp_o.pslverr = access && req_i.pwrite;

    // Data only on a read
    assign resp_o.prdata = (access && !req_i.pwrite) ? BOOT_IMAGE[word_idx] : '0;

endmodule

// File: hdl/uncore_decoder.sv
// APB address decoder, steers each upstream transfer to ROM, CLINT or DRAM and merges responses
`timescale 1ns/1ps

module uncore_decoder
    import apb_pkg::*;
    import uncore_pkg::*;
(
    input  logic      clk,
    input  logic      uncore_areset_n,
    // Upstream slave port
    input  apb_req_t  up_req_i,
    output apb_resp_t up_resp_o,
    // Target ports
    output apb_req_t  rom_req_o,
    input  apb_resp_t rom_resp_i,
    output apb_req_t  clint_req_o,
    input  apb_resp_t clint_resp_i,
    output apb_req_t  dram_req_o,
    input  apb_resp_t dram_resp_i
);

    xfer_state_e state_q;
    xfer_state_e state_d;
    region_e     region_q;
    region_e     region_d;
    region_e     sel_region;
    logic        setup_phase;
    logic        access_phase;
    apb_resp_t   sel_resp;

    // Unsigned wrap makes addresses below base fall outside
    function automatic logic in_window(
        input logic [ADDR_W-1:0] addr,
        input logic [ADDR_W-1:0] base,
        input logic [ADDR_W-1:0] size
    );
        return (addr - base) < size;
    endfunction

    // Copy of the request with psel kept only for one target
    function automatic apb_req_t fwd(
        input apb_req_t req,
        input region_e  cur,
        input logic     in_access,
        input region_e  target
    );
        apb_req_t out;
        out         = req;
        out.psel    = req.psel && (cur == target);
        out.penable = out.psel && req.penable && in_access;
        return out;
    endfunction

    // --------------------
    // Region decode
    // --------------------
    always_comb begin
        if (in_window(up_req_i.paddr, ROM_BASE, ROM_END - ROM_BASE)) begin
            region_d = REGION_ROM;
        end else if (in_window(up_req_i.paddr, CLINT_BASE, CLINT_END - CLINT_BASE)) begin
            region_d = REGION_CLINT;
        end else if (in_window(up_req_i.paddr, DRAM_BASE, DRAM_SIZE)) begin
            region_d = REGION_DRAM;
        end else begin
            region_d = REGION_NONE;
        end
    end

    // Setup cycle uses the live decode, access uses the latched one
    assign setup_phase  = (state_q != ACCESS) && up_req_i.psel && !up_req_i.penable;
    assign access_phase = (state_q == ACCESS) && up_req_i.psel && up_req_i.penable;
    assign sel_region   = (state_q == ACCESS) ? region_q : region_d;

    // --------------------
    // Transfer FSM
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            // SETUP marks a finished transfer where a new setup may follow
            IDLE, SETUP: begin
                state_d = setup_phase ? ACCESS : IDLE;
            end
            ACCESS: begin
                if (!up_req_i.psel) begin
                    // Master gave up, nothing to answer
                    state_d = IDLE;
                end else if (up_req_i.penable && sel_resp.pready) begin
                    state_d = SETUP;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge uncore_areset_n) begin
        if (!uncore_areset_n) begin
            state_q  <= IDLE;
            region_q <= REGION_NONE;
        end else begin
            state_q <= state_d;
            // Region held for the whole access phase
            if (setup_phase) begin
                region_q <= region_d;
            end
        end
    end

    // --------------------
    // Request fan-out
    // --------------------
    assign rom_req_o   = fwd(up_req_i, sel_region, state_q == ACCESS, REGION_ROM);
    assign clint_req_o = fwd(up_req_i, sel_region, state_q == ACCESS, REGION_CLINT);
    assign dram_req_o  = fwd(up_req_i, sel_region, state_q == ACCESS, REGION_DRAM);

    // --------------------
    // Response merge
    // --------------------
    always_comb begin
        case (region_q)
            REGION_ROM:   sel_resp = rom_resp_i;
            REGION_CLINT: sel_resp = clint_resp_i;
            REGION_DRAM:  sel_resp = dram_resp_i;
            // Unmapped, answered here at once with an error
            default:      sel_resp = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};
        endcase
    end

    // Quiet bus outside access
    assign up_resp_o = access_phase ? sel_resp : '0;

endmodule

// File: hdl/uncore_pkg.sv
// Uncore address map, target regions, CLINT register offsets and the boot image
package uncore_pkg;

    // Decoded transfer target
    typedef enum logic [1:0] {
        REGION_ROM,
        REGION_CLINT,
        REGION_DRAM,
        REGION_NONE
    } region_e;

    // --------------------
    // Address map
    // --------------------
    // END is exclusive
    localparam logic [apb_pkg::ADDR_W-1:0] ROM_BASE   = 32'h0000_0000;
    localparam logic [apb_pkg::ADDR_W-1:0] ROM_END    = 32'h0001_0000;
    localparam logic [apb_pkg::ADDR_W-1:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [apb_pkg::ADDR_W-1:0] CLINT_END  = 32'h0200_C000;
    // 512 MB window, rebased to zero on the external port
    localparam logic [apb_pkg::ADDR_W-1:0] DRAM_BASE  = 32'h8000_0000;
    localparam logic [apb_pkg::ADDR_W-1:0] DRAM_SIZE  = 32'h2000_0000;

    // --------------------
    // CLINT offsets
    // --------------------
    // Single hart, so one msip and one mtimecmp
    localparam logic [apb_pkg::ADDR_W-1:0] MSIP_OFS        = 32'h0000_0000;
    localparam logic [apb_pkg::ADDR_W-1:0] MTIMECMP_LO_OFS = 32'h0000_4000;
    localparam logic [apb_pkg::ADDR_W-1:0] MTIMECMP_HI_OFS = 32'h0000_4004;
    localparam logic [apb_pkg::ADDR_W-1:0] MTIME_LO_OFS    = 32'h0000_BFF8;
    localparam logic [apb_pkg::ADDR_W-1:0] MTIME_HI_OFS    = 32'h0000_BFFC;

    // --------------------
    // Boot image
    // --------------------
    // Aliased over the whole ROM region
    localparam int unsigned BOOT_WORDS = 16;

    localparam logic [0:BOOT_WORDS-1][apb_pkg::DATA_W-1:0] BOOT_IMAGE = '{
        32'hf140_2573,  // csrr a0, mhartid
        32'h0000_0597,  // auipc a1, 0
        32'h03c5_8593,  // addi a1, a1, 60
        32'h8000_02b7,  // lui t0, 0x80000
        32'h0002_8067,  // jr t0 into DRAM
        32'h0000_0013,
        32'h0000_0013,
        32'h0000_0013,
        32'h0000_0013,
        32'h0000_0013,
        32'h0000_0013,
        32'h0000_0013,
        32'h0000_0013,
        32'h0000_0013,
        32'h1050_0073,  // wfi
        32'hffdf_f06f   // j back to wfi
    };

endpackage

// File: hdl/apb_pkg.sv
// APB bus types and widths, imported by every uncore block and the testbench
package apb_pkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;

    // Master to slave, held stable by the master until pready
    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        logic              pwrite;
        logic [DATA_W-1:0] pwdata;
        logic              psel;
        logic              penable;
    } apb_req_t;

    // Slave to master, only meaningful in the access phase
    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_resp_t;

    // --------------------
    // Transfer phases
    // --------------------
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } xfer_state_e;

endpackage
